// ==== verilog.f ====
design/arithPkg.sv
design/PrefixAndOr.sv
design/Sub.sv
design/Add.sv
design/opIf.sv
design/OperandReg.sv
design/ArithCore.sv
design/ArithUnit.sv
verif/ClockGen.sv
verif/ArithTb.sv

// ==== Makefile ====
# Verilator build and run of the arithmetic unit testbench

LOG = sim.log

all: run

build:
	verilator --binary --timing -f verilog.f --top-module ArithTb -o simv

run: build
	./obj_dir/simv | tee $(LOG)
	grep -q "^=== PASS ===$$" $(LOG)

lint:
	verilator --lint-only --timing -Wall -f verilog.f --top-module ArithTb

clean:
	rm -rf obj_dir $(LOG)

.PHONY: all build run lint clean

// ==== verif/ArithTb.sv ====
`timescale 1ns/1ns

// directed tests for the two stage arithmetic unit
module ArithTb import arithPkg::*; ();

	// one expected result, in send order
	typedef struct packed {
		logic [dataWidth-1:0] res;
		logic                 carry;
		logic                 zero;
		int                   cycle; // cycle count when outValid is due
	} expectEntry_t;

	logic                 clk;
	logic                 arstN;
	logic                 inValid;
	arithOp_t             inOp;
	logic [dataWidth-1:0] inA;
	logic [dataWidth-1:0] inB;
	logic                 outValid;
	logic [dataWidth-1:0] result;
	logic                 carry;
	logic                 zero;

	expectEntry_t expQ[$]; // ops in flight
	int seed = 32'hdb5e;
	int cycleCount = 0;
	int opsSent = 0;
	int dataErrors = 0;
	int flagErrors = 0;
	int protocolErrors = 0;

	ClockGen #(.period(4), .resetCycles(5)) clkGen (.clk(clk), .arstN(arstN));

	ArithUnit u_dut (
		.clk(clk),
		.arstN(arstN),
		.inValid(inValid),
		.inOp(inOp),
		.inA(inA),
		.inB(inB),
		.outValid(outValid),
		.result(result),
		.carry(carry),
		.zero(zero)
	);

	// cycle counter and run limit
	always @(posedge clk) begin
		cycleCount <= cycleCount + 1;
		if (cycleCount >= 2 * opsSent + 100) begin
			$display("timeout: run still going after %0d cycles", cycleCount);
			$display("=== FAIL ===");
			$finish;
		end
	end

	task automatic checkData(input string name, input logic [dataWidth-1:0] got,
		input logic [dataWidth-1:0] exp);
		if (got !== exp) begin
			dataErrors++;
			$display("[ERROR] %s got %h expected %h", name, got, exp);
		end
	endtask

	task automatic checkFlag(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			flagErrors++;
			$display("[ERROR] %s got %h expected %h", name, got, exp);
		end
	endtask

	// outputs are sampled mid cycle, away from the edge
	always @(negedge clk) begin : monitor
		expectEntry_t e;
		if (outValid === 1'b1) begin
			if (expQ.size() == 0) begin
				protocolErrors++;
				$display("outValid high at cycle %0d with no operation pending", cycleCount);
			end else begin
				e = expQ.pop_front();
				if (cycleCount != e.cycle) begin
					protocolErrors++;
					$display("result came at cycle %0d but was due at cycle %0d",
						cycleCount, e.cycle);
				end
				checkData("result", result, e.res);
				checkFlag("carry", carry, e.carry);
				checkFlag("zero", zero, e.zero);
			end
		end
	end

	function automatic logic [dataWidth-1:0] randomWord();
		logic [31:0] r;
		r = $random(seed);
		return r[dataWidth-1:0];
	endfunction

	// reference arithmetic straight from the result rules
	function automatic expectEntry_t expectedFor(input arithOp_t op,
		input logic [dataWidth-1:0] a, input logic [dataWidth-1:0] b);
		expectEntry_t e;
		logic [dataWidth:0] full;
		e = '0;
		case (op)
			opAdd: begin
				full = {1'b0, a} + {1'b0, b};
				e.res = full[dataWidth-1:0];
				e.carry = full[dataWidth]; // carry out
			end
			opSub: begin
				e.res = a - b; // wraps
				e.carry = (a < b);
			end
			opAbsDiff: begin
				e.res = (a > b) ? a - b : b - a;
				e.carry = (a < b);
			end
			default: begin
				e.res = (a < b) ? a : b; // min
				e.carry = (a < b);
			end
		endcase
		e.zero = (e.res == '0);
		return e;
	endfunction

	task automatic sendOp(input arithOp_t op, input logic [dataWidth-1:0] a,
		input logic [dataWidth-1:0] b);
		expectEntry_t e;
		@(posedge clk);
		#1;
		inValid = 1'b1;
		inOp = op;
		inA = a;
		inB = b;
		e = expectedFor(op, a, b);
		e.cycle = cycleCount + 2; // visible two cycles after the drive
		expQ.push_back(e);
		opsSent++;
	endtask

	task automatic idleCycle();
		@(posedge clk);
		#1;
		inValid = 1'b0;
	endtask

	// stop driving and give the last results their fixed latency to come back
	task automatic drain();
		int waitCycles;
		idleCycle();
		waitCycles = 0;
		while ((expQ.size() > 0) && (waitCycles < 4)) begin
			@(negedge clk);
			waitCycles++;
		end
	endtask

	task automatic resetTest();
		while (arstN !== 1'b1) begin
			@(negedge clk);
			checkFlag("outValid", outValid, 1'b0);
		end
		repeat (3) idleCycle(); // monitor flags any stray pulse
	endtask

	task automatic addTest();
		sendOp(opAdd, 16'h0000, 16'h0000);
		sendOp(opAdd, 16'hffff, 16'hffff);
		sendOp(opAdd, 16'hffff, 16'h0001); // full width ripple
		sendOp(opAdd, 16'h8000, 16'h8000);
		sendOp(opAdd, 16'h0000, 16'hffff);
		repeat (50) sendOp(opAdd, randomWord(), randomWord());
		drain();
	endtask

	task automatic subTest();
		sendOp(opSub, 16'h1234, 16'h1234); // zero result
		sendOp(opSub, 16'h0000, 16'h0000);
		sendOp(opSub, 16'h0005, 16'h0009); // borrow
		sendOp(opSub, 16'h0000, 16'hffff);
		repeat (30) sendOp(opSub, randomWord(), randomWord());
		drain();
	endtask

	task automatic compareOpTest(input arithOp_t op);
		sendOp(op, 16'h9000, 16'h1000); // a > b
		sendOp(op, 16'h1000, 16'h9000); // a < b
		sendOp(op, 16'h4242, 16'h4242);
		repeat (15) sendOp(op, randomWord(), randomWord());
		drain();
	endtask

	task automatic throughputTest();
		logic [dataWidth-1:0] r;
		repeat (20) begin
			r = randomWord();
			sendOp(arithOp_t'(r[1:0]), randomWord(), randomWord());
		end
		drain();
	endtask

	task automatic gapTest();
		logic [dataWidth-1:0] r;
		repeat (25) begin
			r = randomWord();
			sendOp(arithOp_t'(r[1:0]), randomWord(), randomWord());
			repeat (r[3:2]) idleCycle(); // 0 to 3 idle cycles
		end
		drain();
	endtask

	initial begin
		inValid = 1'b0;
		inOp = opAdd;
		inA = '0;
		inB = '0;
		resetTest();
		addTest();
		subTest();
		compareOpTest(opAbsDiff);
		compareOpTest(opMin);
		throughputTest();
		gapTest();
		repeat (4) idleCycle();
		if (expQ.size() != 0) begin
			protocolErrors += expQ.size();
			$display("%0d operations still pending at end of run", expQ.size());
		end
		$display("errors: data %0d, flag %0d, protocol %0d",
			dataErrors, flagErrors, protocolErrors);
		if (dataErrors + flagErrors + protocolErrors == 0) begin
			$display("=== PASS ===");
		end else begin
			$display("=== FAIL ===");
		end
		$finish;
	end

endmodule

// ==== verif/ClockGen.sv ====
`timescale 1ns/1ns

// testbench clock and reset source
module ClockGen #(
	parameter int period      = 4, // ns
	parameter int resetCycles = 5
) (
	output logic clk,
	output logic arstN
);

	initial begin
		clk = 1'b0;
		forever #(period / 2) clk = ~clk;
	end

	initial begin
		arstN = 1'b0; // held from time zero
		repeat (resetCycles) @(posedge clk);
		#1 arstN = 1'b1; // release just after the edge
	end

endmodule

// ==== design/ArithUnit.sv ====
`timescale 1ns/1ns

// two stage arithmetic unit, result two cycles after the strobe
module ArithUnit import arithPkg::*; (
	input  logic                 clk,
	input  logic                 arstN,
	input  logic                 inValid,
	input  arithOp_t             inOp,
	input  logic [dataWidth-1:0] inA,
	input  logic [dataWidth-1:0] inB,
	output logic                 outValid,
	output logic [dataWidth-1:0] result,
	output logic                 carry,
	output logic                 zero
);

	// stage 1 to stage 2
	opIf opBus (
		.clk(clk)
	);

	OperandReg operandRegInst (
		.clk(clk),
		.arstN(arstN),
		.inValid(inValid),
		.inOp(inOp),
		.inA(inA),
		.inB(inB),
		.op(opBus.src)
	);

	ArithCore arithCoreInst (
		.clk(clk),
		.arstN(arstN),
		.op(opBus.dst),
		.outValid(outValid),
		.result(result),
		.carry(carry),
		.zero(zero)
	);

endmodule

// ==== design/ArithCore.sv ====
`timescale 1ns/1ns

// stage 2, datapath, result select and output register
module ArithCore import arithPkg::*; (
	input  logic                 clk,
	input  logic                 arstN,
	opIf.dst                     op,       // registered operation in
	output logic                 outValid,
	output logic [dataWidth-1:0] result,
	output logic                 carry,    // carry out or borrow
	output logic                 zero
);

	logic [dataWidth-1:0] sum;      // a + b
	logic                 addCo;
	logic [dataWidth:0]   aExt;     // zero extended for borrow bit
	logic [dataWidth:0]   bExt;
	logic [dataWidth:0]   diffAB;   // a - b, msb is borrow
	logic [dataWidth:0]   diffBA;   // b - a, msb is borrow
	logic                 borrowAB; // a < b
	logic                 borrowBA; // b < a
	logic [dataWidth-1:0] selResult;
	logic                 selCarry;
	logic                 selZero;

	assign aExt = {1'b0, op.a};
	assign bExt = {1'b0, op.b};

	Add #(
		.width(dataWidth),
		.speed(prefixSpeed)
	) addInst (
		.A(op.a),
		.B(op.b),
		.Ci(1'b0), // plain add, no chaining
		.S(sum),
		.Co(addCo)
	);

	Sub #(
		.width(dataWidth + 1),
		.speed(prefixSpeed)
	) subAbInst (
		.A(aExt),
		.B(bExt),
		.S(diffAB)
	);

	Sub #(
		.width(dataWidth + 1),
		.speed(prefixSpeed)
	) subBaInst (
		.A(bExt),
		.B(aExt),
		.S(diffBA)
	);

	assign borrowAB = diffAB[dataWidth];
	assign borrowBA = diffBA[dataWidth];

	always_comb begin
		selResult = sum;
		selCarry  = addCo;
		case (op.op)
			opAdd: begin
				selResult = sum;
				selCarry  = addCo;
			end
			opSub: begin
				selResult = diffAB[dataWidth-1:0]; // wraps mod 2^width
				selCarry  = borrowAB;
			end
			opAbsDiff: begin
				// a - b only when a > b, equal operands give zero either way
				selResult = borrowBA ? diffAB[dataWidth-1:0] : diffBA[dataWidth-1:0];
				selCarry  = borrowAB;
			end
			opMin: begin
				selResult = borrowAB ? op.a : op.b;
				selCarry  = borrowAB;
			end
			default: ;
		endcase
	end

	assign selZero = (selResult == '0);

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			outValid <= 1'b0;
		end else begin
			outValid <= op.valid;
		end
	end

	// flags and result load together, held between operations
	always_ff @(posedge clk) begin
		if (op.valid) begin
			result <= selResult;
			carry  <= selCarry;
			zero   <= selZero;
		end
	end

endmodule

// ==== design/OperandReg.sv ====
`timescale 1ns/1ns

// stage 1, captures the incoming operation
module OperandReg import arithPkg::*; (
	input  logic                 clk,
	input  logic                 arstN,
	input  logic                 inValid, // new operation strobe
	input  arithOp_t             inOp,
	input  logic [dataWidth-1:0] inA,
	input  logic [dataWidth-1:0] inB,
	opIf.src                     op       // registered operation out
);

	// strobe follows input every cycle
	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			op.valid <= 1'b0;
		end else begin
			op.valid <= inValid;
		end
	end

	// payload only moves with the strobe, holds on idle cycles
	always_ff @(posedge clk) begin
		if (inValid) begin
			op.op <= inOp;
			op.a  <= inA;
			op.b  <= inB;
		end
	end

endmodule

// ==== design/opIf.sv ====
`timescale 1ns/1ns

// one registered operation, operand stage to core
interface opIf import arithPkg::*; (
	input logic clk
);

	logic                 valid; // one cycle per operation
	arithOp_t             op;    // operation code
	logic [dataWidth-1:0] a;     // first operand
	logic [dataWidth-1:0] b;     // second operand

	// operand stage side
	modport src (
		input  clk,
		output valid, op, a, b
	);

	// core side
	modport dst (
		input clk, valid, op, a, b
	);

endinterface

// ==== design/Add.sv ====
`timescale 1ns/1ns

// prefix adder, {Co,S} = A + B + Ci
module Add import arithPkg::*; #(
	parameter int width = dataWidth,  // word width, 2 or more
	parameter int speed = prefixSpeed // prefix network form
) (
	input  logic [width-1:0] A,
	input  logic [width-1:0] B,
	input  logic             Ci, // carry in
	output logic [width-1:0] S,  // sum
	output logic             Co  // carry out
);

	logic [width-1:0] gIn;  // per-bit generate
	logic [width-1:0] pIn;  // per-bit propagate
	logic [width-1:0] gOut; // prefix carries
	logic [width-1:0] hSum; // a ^ b

	// Ci folded into bit 0
	assign hSum[0] = A[0] ^ B[0];
	assign gIn[0]  = (A[0] & B[0]) | (hSum[0] & Ci);
	assign pIn[0]  = 1'b0;

	for (genvar i = 1; i < width; i++) begin : pre
		assign gIn[i]  = A[i] & B[i];
		assign pIn[i]  = A[i] | B[i];
		assign hSum[i] = pIn[i] & ~gIn[i];
	end

	PrefixAndOr #(
		.width(width),
		.speed(speed)
	) prefixInst (
		.GI(gIn),
		.PI(pIn),
		.GO(gOut),
		.PO()
	);

	assign S  = hSum ^ {gOut[width-2:0], Ci};
	assign Co = gOut[width-1]; // carry out of the top bit

endmodule

// ==== design/Sub.sv ====
`timescale 1ns/1ns

// prefix subtractor, S = A - B mod 2^width
module Sub import arithPkg::*; #(
	parameter int width = dataWidth,  // word width, 2 or more
	parameter int speed = prefixSpeed // prefix network form
) (
	input  logic [width-1:0] A, // minuend
	input  logic [width-1:0] B, // subtrahend
	output logic [width-1:0] S  // difference
);

	logic [width-1:0] bInv; // one's complement of B
	logic [width-1:0] gIn;  // per-bit generate
	logic [width-1:0] pIn;  // per-bit propagate
	logic [width-1:0] gOut; // prefix carries
	logic [width-1:0] hSum; // half sum

	assign bInv = ~B;

	// bit 0 sees a carry in of one, so it generates on A|~B
	assign gIn[0]  = A[0] | bInv[0];
	assign pIn[0]  = 1'b0; // nothing below to propagate
	assign hSum[0] = A[0] ^ bInv[0];

	for (genvar i = 1; i < width; i++) begin : pre
		assign gIn[i]  = A[i] & bInv[i];
		assign pIn[i]  = A[i] | bInv[i];
		assign hSum[i] = pIn[i] & ~gIn[i]; // xor from and/or
	end

	PrefixAndOr #(
		.width(width),
		.speed(speed)
	) prefixInst (
		.GI(gIn),
		.PI(pIn),
		.GO(gOut),
		.PO()     // group propagate not needed
	);

	// carry into bit i is prefix generate of bit i-1, bit 0 gets the +1
	assign S = hSum ^ {gOut[width-2:0], 1'b1};

endmodule

// ==== design/PrefixAndOr.sv ====
`timescale 1ns/1ns

// generate/propagate prefix network
// GO[i] = G[i:0], PO[i] = P[i:0] under the (g,p) o (g',p') operator
module PrefixAndOr import arithPkg::*; #(
	parameter int width = dataWidth,  // word width, 2 or more
	parameter int speed = prefixSpeed // network form
) (
	input  logic [width-1:0] GI, // generate in
	input  logic [width-1:0] PI, // propagate in
	output logic [width-1:0] GO, // prefix generate
	output logic [width-1:0] PO  // prefix propagate
);

	localparam int n = width;          // nodes per level
	localparam int m = $clog2(width);  // tree depth

	if (speed == speedSklansky) begin : sklansky
		logic [m:0][n-1:0] gLvl; // per-level generate
		logic [m:0][n-1:0] pLvl; // per-level propagate

		assign gLvl[0] = GI;
		assign pLvl[0] = PI;

		for (genvar l = 1; l <= m; l++) begin : level
			for (genvar i = 0; i < n; i++) begin : node
				localparam int span = 2 ** (l - 1); // half group size
				// upper half of each 2^l group takes the lower half's top node
				if (((i / span) % 2) == 1) begin : black
					localparam int src = (i / span) * span - 1;
					assign gLvl[l][i] = gLvl[l-1][i] | (pLvl[l-1][i] & gLvl[l-1][src]);
					assign pLvl[l][i] = pLvl[l-1][i] & pLvl[l-1][src];
				end else begin : white
					assign gLvl[l][i] = gLvl[l-1][i]; // pass through
					assign pLvl[l][i] = pLvl[l-1][i];
				end
			end
		end

		assign GO = gLvl[m];
		assign PO = pLvl[m];
	end else if (speed == speedBrentKung) begin : brentKung
		// levels 1..m sweep up, levels m+1..2m-1 fill in the gaps
		logic [2*m-1:0][n-1:0] gLvl;
		logic [2*m-1:0][n-1:0] pLvl;

		assign gLvl[0] = GI;
		assign pLvl[0] = PI;

		for (genvar l = 1; l <= m; l++) begin : upLevel
			for (genvar i = 0; i < n; i++) begin : node
				localparam int grp  = 2 ** l;       // group size
				localparam int half = 2 ** (l - 1);
				if (((i + 1) % grp) == 0) begin : black
					// top of group merges with top of its lower half
					assign gLvl[l][i] = gLvl[l-1][i] | (pLvl[l-1][i] & gLvl[l-1][i-half]);
					assign pLvl[l][i] = pLvl[l-1][i] & pLvl[l-1][i-half];
				end else begin : white
					assign gLvl[l][i] = gLvl[l-1][i];
					assign pLvl[l][i] = pLvl[l-1][i];
				end
			end
		end

		for (genvar l = m + 1; l < 2 * m; l++) begin : downLevel
			for (genvar i = 0; i < n; i++) begin : node
				localparam int grp  = 2 ** (2 * m - l); // shrinks each level
				localparam int half = grp / 2;
				// mid node of every group but the first picks up the full prefix below
				if ((i >= grp) && (((i + 1) % grp) == half)) begin : black
					assign gLvl[l][i] = gLvl[l-1][i] | (pLvl[l-1][i] & gLvl[l-1][i-half]);
					assign pLvl[l][i] = pLvl[l-1][i] & pLvl[l-1][i-half];
				end else begin : white
					assign gLvl[l][i] = gLvl[l-1][i];
					assign pLvl[l][i] = pLvl[l-1][i];
				end
			end
		end

		assign GO = gLvl[2*m-1];
		assign PO = pLvl[2*m-1];
	end else begin : serial
		// speedSerial, also the fallback for an unknown speed
		logic [n-1:0] gChain;
		logic [n-1:0] pChain;

		assign gChain[0] = GI[0];
		assign pChain[0] = PI[0];

		for (genvar i = 1; i < n; i++) begin : node
			assign gChain[i] = GI[i] | (PI[i] & gChain[i-1]); // ripple
			assign pChain[i] = PI[i] & pChain[i-1];
		end

		assign GO = gChain;
		assign PO = pChain;
	end

endmodule

// ==== design/arithPkg.sv ====
package arithPkg;

	// operand and result width
	localparam int dataWidth = 16;

	// prefix network forms
	localparam int speedSerial    = 0; // ripple chain, smallest
	localparam int speedBrentKung = 1; // 2*log2(n)-1 levels, few nodes
	localparam int speedSklansky  = 2; // log2(n) levels, high fanout

	// form used by the adders of the unit
	localparam int prefixSpeed = speedSklansky;

	// operation select
	typedef enum logic [1:0] {
		opAdd     = 2'd0, // a + b, carry out
		opSub     = 2'd1, // a - b, borrow
		opAbsDiff = 2'd2, // |a - b|
		opMin     = 2'd3  // smaller of a, b
	} arithOp_t;

endpackage
